/* list.f */
+incdir+hw
hw/axi_bus_pkg.sv
hw/periph_map_pkg.sv
hw/reg_bank.sv
hw/stream_fifo.sv
hw/axi_write_engine.sv
hw/axi_read_engine.sv
hw/axi_periph_ctrl.sv
test/axi_periph_ctrl_properties.sv
test/axi_periph_ctrl_tb.sv

/* Bender.yml */
package:
  name: axi_periph_ctrl

export_include_dirs:
  - hw

sources:
  - files:
      - hw/axi_bus_pkg.sv
      - hw/periph_map_pkg.sv
      - hw/reg_bank.sv
      - hw/stream_fifo.sv
      - hw/axi_write_engine.sv
      - hw/axi_read_engine.sv
      - hw/axi_periph_ctrl.sv
  - target: test
    files:
      - test/axi_periph_ctrl_properties.sv
      - test/axi_periph_ctrl_tb.sv

/* test/axi_periph_ctrl_tb.sv */
// Directed testbench for axi_periph_ctrl with bus tasks, checker, LCG and timeout
`default_nettype none
`include "periph_ctrl_config.svh"

module axi_periph_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 2000;      // About ten times the directed sequence

    logic clk = 1'b0;
    logic rst_n;
    logic [`PC_ID_W-1:0]   awid_i;
    logic [`PC_ADDR_W-1:0] awaddr_i;
    axi_bus_pkg::burst_e   awburst_i;
    logic                  awvalid_i, awready_o;
    logic [`PC_DATA_W-1:0] wdata_i;
    logic                  wlast_i, wvalid_i, wready_o;
    logic [`PC_ID_W-1:0]   bid_o;
    axi_bus_pkg::resp_e    bresp_o;
    logic                  bvalid_o, bready_i;
    logic [`PC_ID_W-1:0]   arid_i;
    logic [`PC_ADDR_W-1:0] araddr_i;
    axi_bus_pkg::burst_e   arburst_i;
    logic [`PC_LEN_W-1:0]  arlen_i;
    logic                  arvalid_i, arready_o;
    logic [`PC_ID_W-1:0]   rid_o;
    logic [`PC_DATA_W-1:0] rdata_o;
    axi_bus_pkg::resp_e    rresp_o;
    logic                  rlast_o, rvalid_o, rready_i;
    logic [`PC_DATA_W*`PC_REG_NUM-1:0] stat_reg_i, conf_reg_o;
    logic [`PC_DATA_W-1:0] wst_data_o;
    logic                  wst_valid_o, wst_ready_i;

    logic [7:0]  wbuf [0:7];                   // Write beats to send
    logic [7:0]  rdat [0:7];                   // Collected R beats
    logic [1:0]  rrsp [0:7];
    logic        rlst [0:7];
    logic [7:0]  wst_seen [0:31];              // Bytes leaving the stream port
    int          wst_cnt = 0;
    int          w_beats = 0;                  // Accepted W beats
    int          cycles = 0;
    logic [31:0] rng_state = 32'hd1ae_17b9;
    axi_bus_pkg::resp_e bresp_got;

    axi_periph_ctrl axi_periph_ctrl_inst (.*);

    bind axi_periph_ctrl axi_periph_ctrl_properties u_props (
        .clk(clk), .rst_n(rst_n),
        .bvalid_i(bvalid_o), .bready_i(bready_i),
        .rvalid_i(rvalid_o), .rready_i(rready_i), .rdata_i(rdata_o),
        .rresp_i(rresp_o), .rlast_i(rlast_o), .rid_i(rid_o),
        .wst_valid_i(wst_valid_o), .wst_ready_i(wst_ready_i), .wst_data_i(wst_data_o)
    );

    always #2 clk = ~clk;                      // 4 ns period

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (axi_periph_ctrl_inst.u_props.assert_fails != 0) begin
            $display("Handshake assertion failed before cycle %0d", cycles);
            $display("Simulation failed");
            $fatal(1);
        end else if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    // Mid-cycle monitor of handshakes that complete at the next rising edge
    always @(negedge clk) begin
        if (rst_n && wst_valid_o && wst_ready_i) begin
            wst_seen[wst_cnt] = wst_data_o;
            wst_cnt = wst_cnt + 1;
        end
        if (rst_n && wvalid_i && wready_o) w_beats = w_beats + 1;
    end

    function automatic logic [7:0] rand_byte();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[23:16];               // Upper bits mix better
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // One burst from wbuf with AW held until the last beat
    task automatic axi_write(input logic [31:0] addr, input axi_bus_pkg::burst_e burst,
                             input int n, input logic [3:0] id,
                             output axi_bus_pkg::resp_e resp);
        awid_i    = id;
        awaddr_i  = addr;
        awburst_i = burst;
        awvalid_i = 1'b1;
        for (int i = 0; i < n; i++) begin
            wdata_i  = wbuf[i];
            wlast_i  = (i == n - 1);
            wvalid_i = 1'b1;
            @(negedge clk);
            while (!wready_o) @(negedge clk);  // FIFO back-pressure
            check("awready_o", awready_o, (i == n - 1));
            @(posedge clk);
            #0.5;
        end
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        wlast_i   = 1'b0;
        @(negedge clk);
        while (!bvalid_o) @(negedge clk);
        check("bid_o", bid_o, id);
        resp = bresp_o;
        @(posedge clk);                        // Response left waiting one cycle
        #0.5;
        bready_i = 1'b1;
        @(posedge clk);
        #0.5;
        bready_i = 1'b0;
    endtask

    // Collects len+1 beats while throttle toggles rready from the LCG
    task automatic axi_read(input logic [31:0] addr, input axi_bus_pkg::burst_e burst,
                            input logic [7:0] len, input logic [3:0] id, input logic throttle);
        int         got;
        logic       ar_taken;
        logic [7:0] coin;
        got       = 0;
        arid_i    = id;
        araddr_i  = addr;
        arburst_i = burst;
        arlen_i   = len;
        arvalid_i = 1'b1;
        rready_i  = 1'b1;
        while (got <= len) begin
            @(negedge clk);
            ar_taken = arvalid_i && arready_o;
            if (rvalid_o && rready_i) begin
                rdat[got] = rdata_o;
                rrsp[got] = rresp_o;
                rlst[got] = rlast_o;
                check("rid_o", rid_o, id);
                got++;
            end
            @(posedge clk);
            #0.5;
            if (ar_taken) arvalid_i = 1'b0;  // AR done after the last load
            coin     = rand_byte();
            rready_i = throttle ? coin[0] : 1'b1;
        end
        rready_i = 1'b0;
    endtask

    task automatic reset_values();
        check("conf_reg_o", conf_reg_o, 0);
        check("bvalid_o", bvalid_o, 0);
        check("rvalid_o", rvalid_o, 0);
        check("wst_valid_o", wst_valid_o, 0);
        check("awready_o", awready_o, 0);
        check("arready_o", arready_o, 0);
    endtask

    task automatic conf_access();
        for (int i = 0; i < 4; i++) wbuf[i] = rand_byte();
        axi_write(`PC_CONF_BASE, axi_bus_pkg::BURST_INCR, 4, 4'h1, bresp_got);
        check("bresp_o", bresp_got, axi_bus_pkg::RESP_OKAY);
        check("conf_reg_o", conf_reg_o, {wbuf[3], wbuf[2], wbuf[1], wbuf[0]});
        axi_read(`PC_CONF_BASE, axi_bus_pkg::BURST_INCR, 8'd3, 4'h2, 1'b1);
        for (int i = 0; i < 4; i++) begin
            check("rdata_o", rdat[i], wbuf[i]);
            check("rresp_o", rrsp[i], axi_bus_pkg::RESP_OKAY);
            check("rlast_o", rlst[i], (i == 3));
        end
    endtask

    task automatic status_reads();
        stat_reg_i = 32'h44_33_22_11;          // Byte n holds 0x11*(n+1)
        axi_read(`PC_STAT_BASE + 2, axi_bus_pkg::BURST_FIXED, 8'd2, 4'h3, 1'b0);
        for (int i = 0; i < 3; i++) begin
            check("rdata_o", rdat[i], 8'h33);
            check("rresp_o", rrsp[i], axi_bus_pkg::RESP_OKAY);
        end
        axi_read(`PC_STAT_BASE, axi_bus_pkg::BURST_INCR, 8'd3, 4'h4, 1'b0);
        for (int i = 0; i < 4; i++) check("rdata_o", rdat[i], 8'h11 * (i + 1));
    endtask

    task automatic fifo_count_read();
        int base;
        base        = wst_cnt;
        wst_ready_i = 1'b0;
        for (int i = 0; i < 3; i++) wbuf[i] = rand_byte();
        axi_write(`PC_WST_BASE, axi_bus_pkg::BURST_FIXED, 3, 4'h5, bresp_got);
        check("bresp_o", bresp_got, axi_bus_pkg::RESP_OKAY);
        axi_read(`PC_WST_BASE, axi_bus_pkg::BURST_INCR, 8'd0, 4'h6, 1'b0);
        check("rdata_o", rdat[0], 3);
        check("rresp_o", rrsp[0], axi_bus_pkg::RESP_OKAY);
        wst_ready_i = 1'b1;
        while (wst_cnt < base + 3) begin
            @(posedge clk);
            #0.5;
        end
        for (int i = 0; i < 3; i++) check("wst_data_o", wst_seen[base + i], wbuf[i]);
    endtask

    task automatic wst_backpressure();
        int base_out;
        int base_beats;
        base_out    = wst_cnt;
        base_beats  = w_beats;
        wst_ready_i = 1'b0;
        for (int i = 0; i < 6; i++) wbuf[i] = rand_byte();
        fork
            axi_write(`PC_WST_BASE, axi_bus_pkg::BURST_FIXED, 6, 4'h7, bresp_got);
            begin
                while (w_beats < base_beats + 4) @(posedge clk);
                repeat (3) @(posedge clk);     // FIFO full so W must hold
                @(negedge clk);
                check("wready_o", wready_o, 0);
                check("w_beats", w_beats, base_beats + 4);
                @(posedge clk);
                #0.5;
                wst_ready_i = 1'b1;
            end
        join
        check("bresp_o", bresp_got, axi_bus_pkg::RESP_OKAY);
        while (wst_cnt < base_out + 6) begin
            @(posedge clk);
            #0.5;
        end
        for (int i = 0; i < 6; i++) check("wst_data_o", wst_seen[base_out + i], wbuf[i]);
    endtask

    task automatic decode_errors();
        logic [31:0] conf_before;
        conf_before = conf_reg_o;
        wbuf[0] = 8'ha5;
        wbuf[1] = 8'h5a;
        axi_write(32'h3000_0000, axi_bus_pkg::BURST_INCR, 2, 4'h8, bresp_got);
        check("bresp_o", bresp_got, axi_bus_pkg::RESP_DECERR);
        check("conf_reg_o", conf_reg_o, conf_before);
        axi_write(`PC_STAT_BASE, axi_bus_pkg::BURST_FIXED, 1, 4'h9, bresp_got);  // Read only
        check("bresp_o", bresp_got, axi_bus_pkg::RESP_DECERR);
        check("conf_reg_o", conf_reg_o, conf_before);
        axi_read(32'h3000_0000, axi_bus_pkg::BURST_INCR, 8'd1, 4'ha, 1'b0);
        for (int i = 0; i < 2; i++) begin
            check("rresp_o", rrsp[i], axi_bus_pkg::RESP_DECERR);
            check("rdata_o", rdat[i], 0);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        awid_i      = '0;
        awaddr_i    = '0;
        awburst_i   = axi_bus_pkg::BURST_FIXED;
        awvalid_i   = 1'b0;
        wdata_i     = '0;
        wlast_i     = 1'b0;
        wvalid_i    = 1'b0;
        bready_i    = 1'b0;
        arid_i      = '0;
        araddr_i    = '0;
        arburst_i   = axi_bus_pkg::BURST_FIXED;
        arlen_i     = '0;
        arvalid_i   = 1'b0;
        rready_i    = 1'b0;
        stat_reg_i  = '0;
        wst_ready_i = 1'b0;
        repeat (3) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        @(negedge clk);
        reset_values();
        @(posedge clk);
        #0.5;
        conf_access();
        status_reads();
        fifo_count_read();
        wst_backpressure();
        decode_errors();
        repeat (2) @(posedge clk);
        if (axi_periph_ctrl_inst.u_props.assert_fails != 0) begin
            $display("%0d handshake assertion failure(s)",
                     axi_periph_ctrl_inst.u_props.assert_fails);
            $display("Simulation failed");
            $fatal(1);
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* test/axi_periph_ctrl_properties.sv */
// Concurrent handshake assertions for the B, R and stream output channels
`default_nettype none

module axi_periph_ctrl_properties (
    input wire       clk,
    input wire       rst_n,
    input wire       bvalid_i,
    input wire       bready_i,
    input wire       rvalid_i,
    input wire       rready_i,
    input wire [7:0] rdata_i,
    input wire [1:0] rresp_i,
    input wire       rlast_i,
    input wire [3:0] rid_i,
    input wire       wst_valid_i,
    input wire       wst_ready_i,
    input wire [7:0] wst_data_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int assert_fails = 0;                      // Failed assertion count

    // B response held until taken
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid_i && !bready_i |=> bvalid_i)
        else begin
            assert_fails++;
            $error("bvalid dropped before bready");
        end

    // R beat frozen while stalled
    a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i)
                                  && $stable(rlast_i) && $stable(rid_i))
        else begin
            assert_fails++;
            $error("R channel changed under back-pressure");
        end

    a_wst_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wst_valid_i && !wst_ready_i |=> wst_valid_i && $stable(wst_data_i))
        else begin
            assert_fails++;
            $error("stream output dropped before wst_ready");
        end

endmodule

`default_nettype wire

/* hw/axi_periph_ctrl.sv */
// Top level of the AXI4 peripheral controller wiring engines, bank and FIFO
`default_nettype none
`include "periph_ctrl_config.svh"

module axi_periph_ctrl (
    input  wire                                 clk,
    input  wire                                 rst_n,
    // AW channel
    input  wire  [`PC_ID_W-1:0]                 awid_i,
    input  wire  [`PC_ADDR_W-1:0]               awaddr_i,
    input  wire  axi_bus_pkg::burst_e           awburst_i,
    input  wire                                 awvalid_i,
    output logic                                awready_o,
    // W channel
    input  wire  [`PC_DATA_W-1:0]               wdata_i,
    input  wire                                 wlast_i,
    input  wire                                 wvalid_i,
    output logic                                wready_o,
    // B channel
    output logic [`PC_ID_W-1:0]                 bid_o,
    output axi_bus_pkg::resp_e                  bresp_o,
    output logic                                bvalid_o,
    input  wire                                 bready_i,
    // AR channel
    input  wire  [`PC_ID_W-1:0]                 arid_i,
    input  wire  [`PC_ADDR_W-1:0]               araddr_i,
    input  wire  axi_bus_pkg::burst_e           arburst_i,
    input  wire  [`PC_LEN_W-1:0]                arlen_i,
    input  wire                                 arvalid_i,
    output logic                                arready_o,
    // R channel
    output logic [`PC_ID_W-1:0]                 rid_o,
    output logic [`PC_DATA_W-1:0]               rdata_o,
    output axi_bus_pkg::resp_e                  rresp_o,
    output logic                                rlast_o,
    output logic                                rvalid_o,
    input  wire                                 rready_i,
    // Peripheral side
    input  wire  [`PC_DATA_W*`PC_REG_NUM-1:0]   stat_reg_i,
    output logic [`PC_DATA_W*`PC_REG_NUM-1:0]   conf_reg_o,
    output logic [`PC_DATA_W-1:0]               wst_data_o,
    output logic                                wst_valid_o,
    input  wire                                 wst_ready_i
);

    logic                       conf_we;
    logic [`PC_IDX_W-1:0]       conf_idx;
    logic [`PC_DATA_W-1:0]      conf_wdata;
    logic                       wst_push;
    logic [`PC_DATA_W-1:0]      wst_wdata;
    logic                       wst_full;
    logic [`PC_CNT_W-1:0]       wst_count;   // Read back through the WST address
    periph_map_pkg::region_e    rd_region;
    logic [`PC_IDX_W-1:0]       rd_idx;
    logic [`PC_DATA_W-1:0]      rd_byte;

    axi_write_engine u_wr_engine (
        .clk, .rst_n,
        .awid_i, .awaddr_i, .awburst_i, .awvalid_i, .awready_o,
        .wdata_i, .wlast_i, .wvalid_i, .wready_o,
        .bid_o, .bresp_o, .bvalid_o, .bready_i,
        .wst_full_i   (wst_full),
        .conf_we_o    (conf_we),
        .conf_idx_o   (conf_idx),
        .conf_wdata_o (conf_wdata),
        .wst_push_o   (wst_push),
        .wst_wdata_o  (wst_wdata)
    );

    // Separate bank port, no contention with writes
    axi_read_engine u_rd_engine (
        .clk, .rst_n,
        .arid_i, .araddr_i, .arburst_i, .arlen_i, .arvalid_i, .arready_o,
        .rid_o, .rdata_o, .rresp_o, .rlast_o, .rvalid_o, .rready_i,
        .rd_region_o  (rd_region),
        .rd_idx_o     (rd_idx),
        .rd_byte_i    (rd_byte),
        .wst_count_i  (wst_count)
    );

    reg_bank u_reg_bank (
        .clk, .rst_n,
        .conf_we_i    (conf_we),
        .conf_idx_i   (conf_idx),
        .conf_wdata_i (conf_wdata),
        .stat_reg_i,
        .rd_region_i  (rd_region),
        .rd_idx_i     (rd_idx),
        .rd_byte_o    (rd_byte),
        .conf_reg_o
    );

    stream_fifo u_wst_fifo (
        .clk, .rst_n,
        .push_i       (wst_push),
        .data_i       (wst_wdata),
        .ready_i      (wst_ready_i),
        .full_o       (wst_full),
        .count_o      (wst_count),
        .data_o       (wst_data_o),
        .valid_o      (wst_valid_o)
    );

endmodule

`default_nettype wire

/* hw/axi_read_engine.sv */
// AXI4 AR/R handling with beat counter, read decode and the R beat register
`default_nettype none
`include "periph_ctrl_config.svh"

module axi_read_engine (
    input  wire                         clk,
    input  wire                         rst_n,
    // AR channel
    input  wire  [`PC_ID_W-1:0]         arid_i,
    input  wire  [`PC_ADDR_W-1:0]       araddr_i,
    input  wire  axi_bus_pkg::burst_e   arburst_i,
    input  wire  [`PC_LEN_W-1:0]        arlen_i,
    input  wire                         arvalid_i,
    output logic                        arready_o,
    // R channel
    output logic [`PC_ID_W-1:0]         rid_o,
    output logic [`PC_DATA_W-1:0]       rdata_o,
    output axi_bus_pkg::resp_e          rresp_o,
    output logic                        rlast_o,
    output logic                        rvalid_o,
    input  wire                         rready_i,
    // Register bank and FIFO side
    output periph_map_pkg::region_e     rd_region_o,
    output logic [`PC_IDX_W-1:0]        rd_idx_o,
    input  wire  [`PC_DATA_W-1:0]       rd_byte_i,
    input  wire  [`PC_CNT_W-1:0]        wst_count_i
);

    logic [`PC_LEN_W-1:0]   beat_cnt;       // Beats loaded so far
    logic [`PC_ADDR_W-1:0]  beat_addr;
    logic                   is_last;
    logic                   load;
    logic [`PC_DATA_W-1:0]  beat_data;
    axi_bus_pkg::resp_e     beat_resp;

    assign beat_addr   = (arburst_i == axi_bus_pkg::BURST_INCR) ? araddr_i + beat_cnt
                                                                 : araddr_i;
    assign rd_region_o = periph_map_pkg::region_of(beat_addr);
    assign rd_idx_o    = periph_map_pkg::reg_index_of(beat_addr, rd_region_o);

    // R register empty or being drained
    assign load      = arvalid_i & (~rvalid_o | rready_i);
    assign is_last   = (beat_cnt == arlen_i);
    assign arready_o = load & is_last;      // AR retires with the last load

    // WST reads give the occupancy, bank already zeroes unmapped beats
    always_comb begin
        if (rd_region_o == periph_map_pkg::REGION_WST) begin
            beat_data = {{(`PC_DATA_W - `PC_CNT_W){1'b0}}, wst_count_i};
        end else begin
            beat_data = rd_byte_i;
        end
    end

    assign beat_resp = (rd_region_o == periph_map_pkg::REGION_NONE) ? axi_bus_pkg::RESP_DECERR
                                                                    : axi_bus_pkg::RESP_OKAY;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (load) begin
            beat_cnt <= is_last ? '0 : beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_o <= 1'b0;
        end else if (load) begin
            rvalid_o <= 1'b1;
        end else if (rready_i) begin
            rvalid_o <= 1'b0;               // Taken, nothing new
        end
    end

    // R beat payload, holds under back-pressure
    always_ff @(posedge clk) begin
        if (load) begin
            rid_o   <= arid_i;
            rdata_o <= beat_data;
            rresp_o <= beat_resp;
            rlast_o <= is_last;
        end
    end

endmodule

`default_nettype wire

/* hw/axi_write_engine.sv */
// AXI4 AW/W/B handling with beat counter, write decode and B response register
`default_nettype none
`include "periph_ctrl_config.svh"

module axi_write_engine (
    input  wire                         clk,
    input  wire                         rst_n,
    // AW channel
    input  wire  [`PC_ID_W-1:0]         awid_i,
    input  wire  [`PC_ADDR_W-1:0]       awaddr_i,
    input  wire  axi_bus_pkg::burst_e   awburst_i,
    input  wire                         awvalid_i,
    output logic                        awready_o,
    // W channel
    input  wire  [`PC_DATA_W-1:0]       wdata_i,
    input  wire                         wlast_i,
    input  wire                         wvalid_i,
    output logic                        wready_o,
    // B channel
    output logic [`PC_ID_W-1:0]         bid_o,
    output axi_bus_pkg::resp_e          bresp_o,
    output logic                        bvalid_o,
    input  wire                         bready_i,
    // Register bank and FIFO side
    input  wire                         wst_full_i,
    output logic                        conf_we_o,
    output logic [`PC_IDX_W-1:0]        conf_idx_o,
    output logic [`PC_DATA_W-1:0]       conf_wdata_o,
    output logic                        wst_push_o,
    output logic [`PC_DATA_W-1:0]       wst_wdata_o
);

    logic [`PC_LEN_W-1:0]       beat_cnt;
    logic [`PC_ADDR_W-1:0]      beat_addr;
    periph_map_pkg::region_e    beat_region;
    logic                       target_rdy;
    logic                       beat_err;
    logic                       err_q;          // Sticky over the burst
    logic                       w_hsk;

    // FIXED bursts stay on the start address
    assign beat_addr   = (awburst_i == axi_bus_pkg::BURST_INCR) ? awaddr_i + beat_cnt
                                                                 : awaddr_i;
    assign beat_region = periph_map_pkg::region_of(beat_addr);
    assign beat_err    = (beat_region == periph_map_pkg::REGION_STAT) |
                         (beat_region == periph_map_pkg::REGION_NONE);   // STAT is read only

    // Only a full FIFO holds off a beat
    assign target_rdy = ~((beat_region == periph_map_pkg::REGION_WST) & wst_full_i);
    assign wready_o   = awvalid_i & target_rdy & ~bvalid_o;
    assign w_hsk      = wvalid_i & wready_o;
    assign awready_o  = w_hsk & wlast_i;        // AW retires with the last beat

    // Steering, unmapped beats go nowhere
    assign conf_we_o    = w_hsk & (beat_region == periph_map_pkg::REGION_CONF);
    assign conf_idx_o   = periph_map_pkg::reg_index_of(beat_addr, beat_region);
    assign conf_wdata_o = wdata_i;
    assign wst_push_o   = w_hsk & (beat_region == periph_map_pkg::REGION_WST);
    assign wst_wdata_o  = wdata_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            err_q    <= 1'b0;
        end else if (w_hsk) begin
            beat_cnt <= wlast_i ? '0 : beat_cnt + 1'b1;
            err_q    <= wlast_i ? 1'b0 : (err_q | beat_err);
        end
    end

    // B response register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid_o <= 1'b0;
        end else if (awready_o) begin
            bvalid_o <= 1'b1;
        end else if (bready_i) begin
            bvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (awready_o) begin
            bid_o   <= awid_i;
            bresp_o <= (err_q | beat_err) ? axi_bus_pkg::RESP_DECERR   // Any bad beat
                                          : axi_bus_pkg::RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

/* hw/stream_fifo.sv */
// Write-streaming FIFO with occupancy count and downstream valid/ready output
`default_nettype none
`include "periph_ctrl_config.svh"

module stream_fifo (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         push_i,
    input  wire  [`PC_DATA_W-1:0]       data_i,
    input  wire                         ready_i,
    output logic                        full_o,
    output logic [`PC_CNT_W-1:0]        count_o,
    output logic [`PC_DATA_W-1:0]       data_o,
    output logic                        valid_o
);

    localparam int PTR_W = $clog2(`PC_WST_DEPTH);
    localparam logic [PTR_W-1:0]      LAST_SLOT = PTR_W'(`PC_WST_DEPTH - 1);
    localparam logic [`PC_CNT_W-1:0]  DEPTH     = `PC_WST_DEPTH;

    logic [`PC_DATA_W-1:0] mem [`PC_WST_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic                  do_push;
    logic                  do_pop;

    assign do_pop  = valid_o & ready_i;     // Downstream takes a byte
    assign do_push = push_i & ~full_o;      // Engine never pushes when full anyway

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_o <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count_o <= count_o + 1'b1;
                2'b01:   count_o <= count_o - 1'b1;
                default: count_o <= count_o;    // Both or neither
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= data_i;
    end

    assign full_o  = (count_o == DEPTH);
    assign valid_o = (count_o != '0);
    assign data_o  = mem[rd_ptr];           // Head of queue

endmodule

`default_nettype wire

/* hw/reg_bank.sv */
// Configuration registers with one write port and the conf/status read mux
`default_nettype none
`include "periph_ctrl_config.svh"

module reg_bank (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  conf_we_i,
    input  wire  [`PC_IDX_W-1:0]                 conf_idx_i,
    input  wire  [`PC_DATA_W-1:0]                conf_wdata_i,
    input  wire  [`PC_DATA_W*`PC_REG_NUM-1:0]    stat_reg_i,
    input  wire  periph_map_pkg::region_e        rd_region_i,
    input  wire  [`PC_IDX_W-1:0]                 rd_idx_i,
    output logic [`PC_DATA_W-1:0]                rd_byte_o,
    output logic [`PC_DATA_W*`PC_REG_NUM-1:0]    conf_reg_o
);

    logic [`PC_DATA_W-1:0] conf_q [`PC_REG_NUM];   // Config bytes

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PC_REG_NUM; i++) begin
                conf_q[i] <= '0;
            end
        end else if (conf_we_i) begin
            conf_q[conf_idx_i] <= conf_wdata_i;   // One byte per strobe
        end
    end

    // Flatten, byte 0 in the low bits
    always_comb begin
        for (int i = 0; i < `PC_REG_NUM; i++) begin
            conf_reg_o[i*`PC_DATA_W +: `PC_DATA_W] = conf_q[i];
        end
    end

    // Read port for the read engine
    always_comb begin
        case (rd_region_i)
            periph_map_pkg::REGION_CONF: rd_byte_o = conf_q[rd_idx_i];
            periph_map_pkg::REGION_STAT: rd_byte_o = stat_reg_i[rd_idx_i*`PC_DATA_W +: `PC_DATA_W];
            default:                     rd_byte_o = '0;   // WST and unmapped
        endcase
    end

endmodule

`default_nettype wire

/* hw/periph_map_pkg.sv */
// Region enum and address decode functions for the peripheral map
`default_nettype none
`include "periph_ctrl_config.svh"

package periph_map_pkg;

    typedef enum logic [1:0] {
        REGION_CONF,
        REGION_STAT,
        REGION_WST,
        REGION_NONE
    } region_e;

    localparam logic [`PC_ADDR_W-1:0] REG_SPAN = `PC_REG_NUM * `PC_OFFSET;

    // Unsigned wrap of addr - base also rejects addresses below the base
    function automatic region_e region_of(input logic [`PC_ADDR_W-1:0] addr);
        logic [`PC_ADDR_W-1:0] conf_offs;
        logic [`PC_ADDR_W-1:0] stat_offs;
        conf_offs = addr - `PC_CONF_BASE;
        stat_offs = addr - `PC_STAT_BASE;
        if (conf_offs < REG_SPAN) return REGION_CONF;
        if (stat_offs < REG_SPAN) return REGION_STAT;
        if (addr == `PC_WST_BASE) return REGION_WST;   // Single FIFO, one address
        return REGION_NONE;
    endfunction

    // Register index within its region, zero outside the register regions
    function automatic logic [`PC_IDX_W-1:0] reg_index_of(input logic [`PC_ADDR_W-1:0] addr,
                                                         input region_e region);
        logic [`PC_ADDR_W-1:0] offs;
        case (region)
            REGION_CONF: offs = (addr - `PC_CONF_BASE) / `PC_OFFSET;
            REGION_STAT: offs = (addr - `PC_STAT_BASE) / `PC_OFFSET;
            default:     offs = '0;
        endcase
        return offs[`PC_IDX_W-1:0];
    endfunction

endpackage

`default_nettype wire

/* hw/axi_bus_pkg.sv */
// AXI4 burst type and response code enums
`default_nettype none

package axi_bus_pkg;

    // Only FIXED and INCR are served
    typedef enum logic [1:0] {
        BURST_FIXED = 2'd0,
        BURST_INCR  = 2'd1
    } burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_DECERR = 2'd3     // Unmapped or read-only target
    } resp_e;

endpackage

`default_nettype wire

/* hw/periph_ctrl_config.svh */
// Bus widths, region base addresses, register count and streaming FIFO depth
`ifndef PERIPH_CTRL_CONFIG_SVH
`define PERIPH_CTRL_CONFIG_SVH

// Bus widths
`define PC_DATA_W     8               // Byte-wide data path
`define PC_ADDR_W     32
`define PC_ID_W       4
`define PC_LEN_W      8               // Up to 256 beats

// Address map, byte access so offset is 1
`define PC_CONF_BASE  32'h2000_0000
`define PC_STAT_BASE  32'h2400_0000
`define PC_WST_BASE   32'h2100_0000
`define PC_OFFSET     32'h0000_0001

// Register and FIFO sizing
`define PC_REG_NUM    4               // Same count for conf and status
`define PC_WST_DEPTH  4
`define PC_IDX_W      ($clog2(`PC_REG_NUM))
`define PC_CNT_W      ($clog2(`PC_WST_DEPTH) + 1)   // Holds 0..depth

`endif
